//--- design/loadForward.sv
module loadForward (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  logic                                                       ldValid,
    input  logic [storeQueuePkg::sqnWidth-1:0]                         ldSqN,
    input  logic [31:0]                                                ldAddr,
    input  logic                                                       stallLd,
    input  logic [storeQueuePkg::numEntries-1:0]                       entValid,
    input  logic [storeQueuePkg::numEntries-1:0]                       entReady,
    input  logic [storeQueuePkg::numEntries*storeQueuePkg::sqnWidth-1:0] entSqN,
    input  logic [storeQueuePkg::numEntries*30-1:0]                    entAddr,
    input  logic [storeQueuePkg::numEntries*32-1:0]                    entData,
    input  logic [storeQueuePkg::numEntries*4-1:0]                     entWmask,
    input  logic [1:0]                                                 evValid,
    input  logic [59:0]                                                evAddr,
    input  logic [63:0]                                                evData,
    input  logic [7:0]                                                 evWmask,
    output logic [31:0]                                                fwdData,
    output logic [3:0]                                                 fwdMask
);
    import storeQueuePkg::*;

    logic [31:0] lookupData;
    logic [3:0]  lookupMask;

    function automatic logic [31:0] mergeLanes(input logic [31:0] base,
                                               input logic [31:0] data,
                                               input logic [3:0] mask);
        logic [31:0] merged;
        merged = base;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                merged[b*8 +: 8] = data[b*8 +: 8];
        end
        return merged;
    endfunction

    // Later matches win per lane, so walk oldest to youngest
    always_comb begin
        lookupData = '0;
        lookupMask = '0;
        for (int i = 0; i < 2; i++) begin
            if (ldValid && evValid[i] && evAddr[i*30 +: 30] == ldAddr[31:2]) begin
                lookupData = mergeLanes(lookupData, evData[i*32 +: 32], evWmask[i*4 +: 4]);
                lookupMask = lookupMask | evWmask[i*4 +: 4];
            end
        end
        for (int i = 0; i < numEntries; i++) begin
            if (ldValid && entValid[i] && entAddr[i*30 +: 30] == ldAddr[31:2] &&
                ($signed(entSqN[i*sqnWidth +: sqnWidth] - ldSqN) < 0 || entReady[i])) begin
                lookupData = mergeLanes(lookupData, entData[i*32 +: 32], entWmask[i*4 +: 4]);
                lookupMask = lookupMask | entWmask[i*4 +: 4];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            fwdMask <= '0;
        else if (!stallLd)
            fwdMask <= lookupMask;
    end

    always_ff @(posedge clk) begin
        if (!stallLd)
            fwdData <= lookupData;
    end

endmodule

//--- design/storeBuffer.sv
module storeBuffer (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  logic                                                       enqValid,
    input  logic [storeQueuePkg::idxWidth-1:0]                         enqIdx,
    input  logic [storeQueuePkg::sqnWidth-1:0]                         enqSqN,
    input  logic [29:0]                                                enqAddr,
    input  logic [31:0]                                                enqData,
    input  logic [3:0]                                                 enqWmask,
    input  logic [storeQueuePkg::sqnWidth-1:0]                         curSqN,
    input  logic                                                       brTaken,
    input  logic [storeQueuePkg::sqnWidth-1:0]                         brSqN,
    input  logic                                                       brFlush,
    input  logic [storeQueuePkg::sqnWidth-1:0]                         brStoreSqN,
    input  logic                                                       deq,
    output logic [storeQueuePkg::sqnWidth-1:0]                         baseIdx,
    output logic                                                       headValid,
    output logic                                                       headReady,
    output logic [29:0]                                                headAddr,
    output logic [31:0]                                                headData,
    output logic [3:0]                                                 headWmask,
    output logic [storeQueuePkg::numEntries-1:0]                       entValid,
    output logic [storeQueuePkg::numEntries-1:0]                       entReady,
    output logic [storeQueuePkg::numEntries*storeQueuePkg::sqnWidth-1:0] entSqN,
    output logic [storeQueuePkg::numEntries*30-1:0]                    entAddr,
    output logic [storeQueuePkg::numEntries*32-1:0]                    entData,
    output logic [storeQueuePkg::numEntries*4-1:0]                     entWmask,
    output logic [1:0]                                                 evValid,
    output logic [59:0]                                                evAddr,
    output logic [63:0]                                                evData,
    output logic [7:0]                                                 evWmask,
    output logic                                                       empty,
    output logic [storeQueuePkg::sqnWidth-1:0]                         maxStoreSqN
);
    import storeQueuePkg::*;

    logic [numEntries-1:0]               validQ;
    logic [numEntries-1:0]               readyQ;
    logic [numEntries-1:0]               committed;
    logic [numEntries-1:0][sqnWidth-1:0] sqnQ;
    logic [numEntries-1:0][29:0]         addrQ;
    logic [numEntries-1:0][31:0]         dataQ;
    logic [numEntries-1:0][3:0]          wmaskQ;

    // Index 1 is the most recent drain
    logic [1:0]                          evValidQ;
    logic [1:0][29:0]                    evAddrQ;
    logic [1:0][31:0]                    evDataQ;
    logic [1:0][3:0]                     evWmaskQ;

    logic [sqnWidth-1:0]                 baseIndex;
    logic [sqnWidth-1:0]                 baseNext;
    logic                                flushing;

    always_comb begin
        for (int i = 0; i < numEntries; i++) begin
            committed[i] = $signed(curSqN - sqnQ[i]) > 0;
        end
    end

    // Base after this edge, so the enqueue slot lines up with a same-cycle shift
    always_comb begin
        baseNext = baseIndex;
        if (deq && !flushing)
            baseNext = baseIndex + 1'b1;
        if (brTaken && brFlush)
            baseNext = brStoreSqN + 1'b1;
    end

    assign baseIdx = baseNext;

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ      <= '0;
            readyQ      <= '0;
            evValidQ    <= '0;
            baseIndex   <= '0;
            flushing    <= 1'b0;
            empty       <= 1'b1;
            maxStoreSqN <= sqnWidth'(numEntries - 1);
        end else begin
            readyQ <= readyQ | committed;

            // Shift down, carrying commits that land during the shift
            if (deq) begin
                validQ   <= {1'b0, validQ[numEntries-1:1]};
                readyQ   <= {1'b0, readyQ[numEntries-1:1] | committed[numEntries-1:1]};
                evValidQ <= {validQ[0], evValidQ[1]};
            end

            if (brTaken) begin
                for (int i = 0; i < numEntries; i++) begin
                    if ($signed(sqnQ[i] - brSqN) > 0 && !readyQ[i])
                        validQ[i] <= 1'b0;
                end
            end

            if (enqValid) begin
                validQ[enqIdx] <= 1'b1;
                readyQ[enqIdx] <= 1'b0;
            end

            // Drained stores of the old stream must not forward after a flush
            if (flushing)
                evValidQ <= '0;

            if (brTaken && brFlush)
                flushing <= 1'b1;
            else if (empty)
                flushing <= 1'b0;

            baseIndex   <= baseNext;
            empty       <= !(|validQ) && !enqValid;
            maxStoreSqN <= baseNext + sqnWidth'(numEntries - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (deq) begin
            sqnQ[numEntries-2:0]  <= sqnQ[numEntries-1:1];
            addrQ[numEntries-2:0] <= addrQ[numEntries-1:1];
            dataQ[numEntries-2:0] <= dataQ[numEntries-1:1];
            wmaskQ[numEntries-2:0] <= wmaskQ[numEntries-1:1];
            evAddrQ  <= {addrQ[0], evAddrQ[1]};
            evDataQ  <= {dataQ[0], evDataQ[1]};
            evWmaskQ <= {wmaskQ[0], evWmaskQ[1]};
        end
        if (enqValid) begin
            sqnQ[enqIdx]   <= enqSqN;
            addrQ[enqIdx]  <= enqAddr;
            dataQ[enqIdx]  <= enqData;
            wmaskQ[enqIdx] <= enqWmask;
        end
    end

    assign headValid = validQ[0];
    assign headReady = readyQ[0];
    assign headAddr  = addrQ[0];
    assign headData  = dataQ[0];
    assign headWmask = wmaskQ[0];

    assign entValid = validQ;
    assign entReady = readyQ;
    assign entSqN   = sqnQ;
    assign entAddr  = addrQ;
    assign entData  = dataQ;
    assign entWmask = wmaskQ;

    assign evValid = evValidQ;
    assign evAddr  = evAddrQ;
    assign evData  = evDataQ;
    assign evWmask = evWmaskQ;

endmodule

//--- design/storeDrain.sv
module storeDrain (
    input  logic        clk,
    input  logic        rst,
    input  logic        headValid,
    input  logic        headReady,
    input  logic [29:0] headAddr,
    input  logic [31:0] headData,
    input  logic [3:0]  headWmask,
    input  logic        brTaken,
    input  logic        ioBusy,
    output logic        deq,
    output logic        memValid,
    output logic [31:0] memAddr,
    output logic [31:0] memData,
    output logic [3:0]  memWmask
);
    import storeQueuePkg::*;

    logic headIsIo;
    logic lastWasIo;

    assign headIsIo = headAddr[29:22] == ioRegionTag;

    // IO writes need an idle bus and a gap after the previous IO write
    assign deq = headValid && headReady && !brTaken &&
                 (!headIsIo || (!ioBusy && !lastWasIo));

    always_ff @(posedge clk) begin
        if (rst) begin
            memValid  <= 1'b0;
            lastWasIo <= 1'b0;
        end else begin
            memValid  <= deq;
            lastWasIo <= deq && headIsIo;
        end
    end

    always_ff @(posedge clk) begin
        if (deq) begin
            memAddr  <= {headAddr, 2'b00};
            memData  <= headData;
            memWmask <= headWmask;
        end
    end

endmodule

//--- design/storeEnqueue.sv
module storeEnqueue (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                stValid,
    input  logic [storeQueuePkg::sqnWidth-1:0]  stSqN,
    input  logic [storeQueuePkg::sqnWidth-1:0]  stStoreSqN,
    input  logic [31:0]                         stAddr,
    input  logic [31:0]                         stData,
    input  logic [3:0]                          stWmask,
    input  storeQueuePkg::AguException          stException,
    input  logic                                brTaken,
    input  logic [storeQueuePkg::sqnWidth-1:0]  brSqN,
    input  logic [storeQueuePkg::sqnWidth-1:0]  baseIdx,
    output logic                                enqValid,
    output logic [storeQueuePkg::idxWidth-1:0]  enqIdx,
    output logic [storeQueuePkg::sqnWidth-1:0]  enqSqN,
    output logic [29:0]                         enqAddr,
    output logic [31:0]                         enqData,
    output logic [3:0]                          enqWmask
);
    import storeQueuePkg::*;

    logic                accept;
    logic                kill;
    logic                stageValid;
    logic [sqnWidth-1:0] stageStoreSqN;

    // Drop faulting stores and stores behind a branch resolving right now
    assign accept = stValid && stException == aguNone &&
                    !(brTaken && $signed(brSqN - stSqN) < 0);

    // A branch older than the staged store still squashes it
    assign kill = brTaken && $signed(brSqN - enqSqN) < 0;

    assign enqValid = stageValid && !kill;

    // Slot taken against the base the buffer holds after this edge
    assign enqIdx = stageStoreSqN[idxWidth-1:0] - baseIdx[idxWidth-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            enqSqN        <= stSqN;
            stageStoreSqN <= stStoreSqN;
            enqAddr       <= stAddr[31:2];
            enqData       <= stData;
            enqWmask      <= stWmask;
        end
    end

endmodule

//--- design/storeQueuePkg.sv
package storeQueuePkg;

    // Instruction and store sequence numbers share one width
    localparam int sqnWidth = 7;

    // Power of two so a slot is just the low sequence-number bits
    localparam int numEntries = 16;
    localparam int idxWidth = 4;

    // Word-address bits 29:22 of memory-mapped IO
    localparam logic [7:0] ioRegionTag = 8'hFF;

    typedef enum logic [1:0] {
        aguNone,
        aguMisaligned,
        aguAccessFault
    } AguException;

endpackage

//--- design/storeQueueTop.sv
module storeQueueTop (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                stValid,
    input  logic [storeQueuePkg::sqnWidth-1:0]  stSqN,
    input  logic [storeQueuePkg::sqnWidth-1:0]  stStoreSqN,
    input  logic [31:0]                         stAddr,
    input  logic [31:0]                         stData,
    input  logic [3:0]                          stWmask,
    input  storeQueuePkg::AguException          stException,
    input  logic                                ldValid,
    input  logic [storeQueuePkg::sqnWidth-1:0]  ldSqN,
    input  logic [31:0]                         ldAddr,
    input  logic                                stallLd,
    input  logic [storeQueuePkg::sqnWidth-1:0]  curSqN,
    input  logic                                brTaken,
    input  logic [storeQueuePkg::sqnWidth-1:0]  brSqN,
    input  logic                                brFlush,
    input  logic [storeQueuePkg::sqnWidth-1:0]  brStoreSqN,
    input  logic                                ioBusy,
    output logic                                memValid,
    output logic [31:0]                         memAddr,
    output logic [31:0]                         memData,
    output logic [3:0]                          memWmask,
    output logic [31:0]                         fwdData,
    output logic [3:0]                          fwdMask,
    output logic                                empty,
    output logic [storeQueuePkg::sqnWidth-1:0]  maxStoreSqN
);
    import storeQueuePkg::*;

    logic                           enqValid;
    logic [idxWidth-1:0]            enqIdx;
    logic [sqnWidth-1:0]            enqSqN;
    logic [29:0]                    enqAddr;
    logic [31:0]                    enqData;
    logic [3:0]                     enqWmask;
    logic [sqnWidth-1:0]            baseIdx;
    logic                           headValid;
    logic                           headReady;
    logic [29:0]                    headAddr;
    logic [31:0]                    headData;
    logic [3:0]                     headWmask;
    logic                           deq;
    logic [numEntries-1:0]          entValid;
    logic [numEntries-1:0]          entReady;
    logic [numEntries*sqnWidth-1:0] entSqN;
    logic [numEntries*30-1:0]       entAddr;
    logic [numEntries*32-1:0]       entData;
    logic [numEntries*4-1:0]        entWmask;
    logic [1:0]                     evValid;
    logic [59:0]                    evAddr;
    logic [63:0]                    evData;
    logic [7:0]                     evWmask;

    storeEnqueue storeEnqueue_i (
        .clk(clk), .rst(rst), .stValid(stValid), .stSqN(stSqN),
        .stStoreSqN(stStoreSqN), .stAddr(stAddr), .stData(stData),
        .stWmask(stWmask), .stException(stException), .brTaken(brTaken),
        .brSqN(brSqN), .baseIdx(baseIdx), .enqValid(enqValid), .enqIdx(enqIdx),
        .enqSqN(enqSqN), .enqAddr(enqAddr), .enqData(enqData), .enqWmask(enqWmask)
    );

    storeBuffer storeBuffer_i (
        .clk(clk), .rst(rst), .enqValid(enqValid), .enqIdx(enqIdx),
        .enqSqN(enqSqN), .enqAddr(enqAddr), .enqData(enqData), .enqWmask(enqWmask),
        .curSqN(curSqN), .brTaken(brTaken), .brSqN(brSqN), .brFlush(brFlush),
        .brStoreSqN(brStoreSqN), .deq(deq), .baseIdx(baseIdx),
        .headValid(headValid), .headReady(headReady), .headAddr(headAddr),
        .headData(headData), .headWmask(headWmask), .entValid(entValid),
        .entReady(entReady), .entSqN(entSqN), .entAddr(entAddr), .entData(entData),
        .entWmask(entWmask), .evValid(evValid), .evAddr(evAddr), .evData(evData),
        .evWmask(evWmask), .empty(empty), .maxStoreSqN(maxStoreSqN)
    );

    loadForward loadForward_i (
        .clk(clk), .rst(rst), .ldValid(ldValid), .ldSqN(ldSqN), .ldAddr(ldAddr),
        .stallLd(stallLd), .entValid(entValid), .entReady(entReady),
        .entSqN(entSqN), .entAddr(entAddr), .entData(entData), .entWmask(entWmask),
        .evValid(evValid), .evAddr(evAddr), .evData(evData), .evWmask(evWmask),
        .fwdData(fwdData), .fwdMask(fwdMask)
    );

    storeDrain storeDrain_i (
        .clk(clk), .rst(rst), .headValid(headValid), .headReady(headReady),
        .headAddr(headAddr), .headData(headData), .headWmask(headWmask),
        .brTaken(brTaken), .ioBusy(ioBusy), .deq(deq), .memValid(memValid),
        .memAddr(memAddr), .memData(memData), .memWmask(memWmask)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only on the pass line
verilator --binary --timing --assert -Wno-fatal --top-module storeQueueTb \
    -f vlog.f -o simv &&
out=$(./obj_dir/simv) &&
echo "$out" &&
echo "$out" | grep -qx "STATUS: PASS" && exit 0 || exit 1

//--- verification/storeQueueTb.sv
module storeQueueTb;
    timeunit 1ns;
    timeprecision 1ps;
    import storeQueuePkg::*;

    logic                clk = 1'b0;
    logic                rst;
    logic                stValid;
    logic [sqnWidth-1:0] stSqN;
    logic [sqnWidth-1:0] stStoreSqN;
    logic [31:0]         stAddr;
    logic [31:0]         stData;
    logic [3:0]          stWmask;
    AguException         stException;
    logic                ldValid;
    logic [sqnWidth-1:0] ldSqN;
    logic [31:0]         ldAddr;
    logic                stallLd;
    logic [sqnWidth-1:0] curSqN;
    logic                brTaken;
    logic [sqnWidth-1:0] brSqN;
    logic                brFlush;
    logic [sqnWidth-1:0] brStoreSqN;
    logic                ioBusy;
    logic                memValid;
    logic [31:0]         memAddr;
    logic [31:0]         memData;
    logic [3:0]          memWmask;
    logic [31:0]         fwdData;
    logic [3:0]          fwdMask;
    logic                empty;
    logic [sqnWidth-1:0] maxStoreSqN;

    // Model of the live queue in storeSqN order, and of the drain history
    logic [sqnWidth-1:0] qSqN[$];
    logic [31:0]         qAddr[$];
    logic [31:0]         qData[$];
    logic [3:0]          qMask[$];
    logic [31:0]         hAddr[$];
    logic [31:0]         hData[$];
    logic [3:0]          hMask[$];

    logic [31:0]         seed = 32'ha8f7_ad8c;
    logic [sqnWidth-1:0] nextSqN;
    logic [sqnWidth-1:0] nextStSqN;
    logic [sqnWidth-1:0] modelBase;
    logic                prevIo;
    logic                isIo;
    logic [35:0]         held;
    logic [31:0]         lastAddr;
    logic [sqnWidth-1:0] keepSqN;
    logic [sqnWidth-1:0] reuseStSqN;
    int                  errors = 0;
    int                  timeouts = 0;
    int                  drains = 0;

    storeQueueTop storeQueueTop_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] nextRand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic logic isOlder(input logic [sqnWidth-1:0] a, input logic [sqnWidth-1:0] b);
        logic [sqnWidth-1:0] diff;
        diff = a - b;
        return diff[sqnWidth-1];
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] base, input logic [31:0] d,
                                               input logic [3:0] m);
        logic [31:0] res;
        res = base;
        for (int b = 0; b < 4; b++) begin
            if (m[b])
                res[b*8 +: 8] = d[b*8 +: 8];
        end
        return res;
    endfunction

    // History oldest first, then queue from the head, later lanes win
    function automatic logic [35:0] expectedForward(input logic [sqnWidth-1:0] lsq,
                                                    input logic [31:0] a);
        logic [31:0] d;
        logic [3:0]  m;
        d = '0;
        m = '0;
        for (int i = 0; i < hAddr.size(); i++) begin
            if (hAddr[i][31:2] == a[31:2]) begin
                d = mergeBytes(d, hData[i], hMask[i]);
                m = m | hMask[i];
            end
        end
        for (int i = 0; i < qAddr.size(); i++) begin
            if (qAddr[i][31:2] == a[31:2] &&
                (isOlder(qSqN[i], lsq) || isOlder(qSqN[i], curSqN))) begin
                d = mergeBytes(d, qData[i], qMask[i]);
                m = m | qMask[i];
            end
        end
        return {m, d};
    endfunction

    function automatic logic [31:0] plainAddr();
        logic [31:0] r;
        r = nextRand();
        return {8'h10, r[23:2], 2'b00};
    endfunction

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic sendStore(input logic [31:0] a, input logic [3:0] m, input AguException exc);
        logic [31:0] d;
        d = nextRand();
        stValid = 1'b1;
        stSqN = nextSqN;
        stStoreSqN = nextStSqN;
        stAddr = a;
        stData = d;
        stWmask = m;
        stException = exc;
        if (exc == aguNone) begin
            qSqN.push_back(nextSqN);
            qAddr.push_back(a);
            qData.push_back(d);
            qMask.push_back(m);
            nextStSqN = nextStSqN + 1'b1;
        end
        nextSqN = nextSqN + 7'd2;
        tick();
        stValid = 1'b0;
        stException = aguNone;
    endtask

    task automatic dropNewest();
        void'(qSqN.pop_back());
        void'(qAddr.pop_back());
        void'(qData.pop_back());
        void'(qMask.pop_back());
    endtask

    task automatic checkLoad(input logic [sqnWidth-1:0] lsq, input logic [31:0] a);
        logic [35:0] expVal;
        ldValid = 1'b1;
        ldSqN = lsq;
        ldAddr = a;
        expVal = expectedForward(lsq, a);
        tick();
        ldValid = 1'b0;
        @(negedge clk);
        assert ({fwdMask, fwdData} == expVal) else begin
            errors++;
            $display("CHECK FAILED at %0t: forward mask %h data %h, expected mask %h data %h",
                     $time, fwdMask, fwdData, expVal[35:32], expVal[31:0]);
        end
        tick();
    endtask

    task automatic waitDrained(input int remain);
        int n;
        n = 0;
        while (qAddr.size() != remain && n < 300) begin
            tick();
            n++;
        end
        if (qAddr.size() != remain) begin
            timeouts++;
            $display("Timeout: the memory port did not drain the stores that were expected");
        end
    endtask

    task automatic checkIdle();
        repeat (3) tick();
        assert (empty && maxStoreSqN == modelBase + 7'd15) else begin
            errors++;
            $display("CHECK FAILED at %0t: empty %b maxStoreSqN %0d, expected maxStoreSqN %0d",
                     $time, empty, maxStoreSqN, modelBase + 7'd15);
        end
    endtask

    // Memory port monitor against the model head
    always @(negedge clk) begin
        isIo = memAddr[31:24] == ioRegionTag;
        if (!rst && memValid) begin
            assert (!(isIo && prevIo)) else begin
                errors++;
                $display("CHECK FAILED at %0t: IO writes on adjacent cycles", $time);
            end
            if (qAddr.size() == 0) begin
                errors++;
                $display("Unexpected memory write to %h at %0t", memAddr, $time);
            end else begin
                assert (memAddr == {qAddr[0][31:2], 2'b00} && memData == qData[0] &&
                        memWmask == qMask[0]) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: write %h %h %h, expected %h %h %h", $time,
                             memAddr, memData, memWmask, qAddr[0], qData[0], qMask[0]);
                end
                hAddr.push_back(qAddr.pop_front());
                hData.push_back(qData.pop_front());
                hMask.push_back(qMask.pop_front());
                void'(qSqN.pop_front());
                if (hAddr.size() > 2) begin
                    void'(hAddr.pop_front());
                    void'(hData.pop_front());
                    void'(hMask.pop_front());
                end
                modelBase = modelBase + 1'b1;
                drains++;
            end
        end
        prevIo = !rst && memValid && isIo;
    end

    initial begin
        rst = 1'b1;
        stValid = 1'b0;
        stSqN = '0;
        stStoreSqN = '0;
        stAddr = '0;
        stData = '0;
        stWmask = '0;
        stException = aguNone;
        ldValid = 1'b0;
        ldSqN = '0;
        ldAddr = '0;
        stallLd = 1'b0;
        curSqN = '0;
        brTaken = 1'b0;
        brSqN = '0;
        brFlush = 1'b0;
        brStoreSqN = '0;
        ioBusy = 1'b0;
        prevIo = 1'b0;
        nextSqN = 7'd1;
        nextStSqN = '0;
        modelBase = '0;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;
        tick();

        // In-order drain, committed after a delay
        for (int i = 0; i < 12; i++)
            sendStore(plainAddr(), nextRand() | 4'b0001, aguNone);
        repeat (4) tick();
        curSqN = nextSqN;
        waitDrained(0);
        checkIdle();

        // Forwarding from IO stores held at the head by a busy bus
        ioBusy = 1'b1;
        keepSqN = nextSqN;
        sendStore(32'hFF00_0100, 4'b0011, aguNone);
        sendStore(32'hFF00_0100, 4'b0110, aguNone);
        sendStore(32'hFF00_0100, 4'b1000, aguNone);
        sendStore(32'hFF00_0100, 4'b1111, aguMisaligned);
        curSqN = keepSqN + 1'b1;
        for (int i = 0; i < 6; i++) begin
            tick();
            assert (!memValid) else begin
                errors++;
                $display("CHECK FAILED at %0t: IO store drained while busy", $time);
            end
        end
        checkLoad(keepSqN + 7'd7, 32'hFF00_0100);

        // Stall holds the last result
        held = {fwdMask, fwdData};
        stallLd = 1'b1;
        ldValid = 1'b1;
        ldSqN = keepSqN;
        ldAddr = 32'hFF00_0100;
        for (int i = 0; i < 3; i++) begin
            tick();
            @(negedge clk);
            assert ({fwdMask, fwdData} == held) else begin
                errors++;
                $display("CHECK FAILED at %0t: forward result changed under stall", $time);
            end
        end
        tick();
        stallLd = 1'b0;
        ldValid = 1'b0;
        checkLoad(keepSqN, 32'hFF00_0100);
        curSqN = nextSqN;
        ioBusy = 1'b0;
        waitDrained(0);
        checkLoad(nextSqN, 32'hFF00_0100);
        checkIdle();

        // Branch kills younger stores in the buffer, in the stage and at the port
        sendStore(plainAddr(), 4'b1111, aguNone);
        keepSqN = nextSqN;
        sendStore(plainAddr(), 4'b0101, aguNone);
        reuseStSqN = nextStSqN;
        sendStore(plainAddr(), 4'b1010, aguNone);
        repeat (3) tick();
        sendStore(plainAddr(), 4'b1100, aguNone);
        brTaken = 1'b1;
        brSqN = keepSqN;
        stValid = 1'b1;
        stSqN = nextSqN;
        stStoreSqN = nextStSqN;
        stAddr = plainAddr();
        stWmask = 4'b1111;
        nextSqN = nextSqN + 7'd2;
        tick();
        brTaken = 1'b0;
        stValid = 1'b0;
        dropNewest();
        dropNewest();
        nextStSqN = reuseStSqN;
        sendStore(plainAddr(), 4'b0011, aguNone);
        sendStore(plainAddr(), 4'b1001, aguNone);
        repeat (2) tick();
        curSqN = nextSqN;
        waitDrained(0);
        checkIdle();

        // Flush rebases the queue
        brTaken = 1'b1;
        brFlush = 1'b1;
        brSqN = nextSqN - 1'b1;
        brStoreSqN = 7'd60;
        tick();
        brTaken = 1'b0;
        brFlush = 1'b0;
        modelBase = 7'd61;
        nextStSqN = 7'd61;
        lastAddr = hAddr[hAddr.size() - 1];
        hAddr.delete();
        hData.delete();
        hMask.delete();
        repeat (3) tick();
        // Old stream no longer forwards
        checkLoad(nextSqN, lastAddr);
        for (int i = 0; i < 4; i++)
            sendStore(plainAddr(), nextRand() | 4'b0010, aguNone);
        repeat (2) tick();
        curSqN = nextSqN;
        waitDrained(0);
        checkIdle();

        $display("drains=%0d errors=%0d timeouts=%0d", drains, errors, timeouts);
        if (errors == 0 && timeouts == 0 && drains == 23) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/storeQueuePkg.sv
design/storeEnqueue.sv
design/storeBuffer.sv
design/loadForward.sv
design/storeDrain.sv
design/storeQueueTop.sv
verification/storeQueueTb.sv
